// ==== hdl/sifhCfgPkg.sv ====
package sifhCfgPkg;

    // photon timestamp from the front end
    localparam int tsWidth = 10;

    // pixel group sharing one bin RAM
    localparam int pixelCount = 4;
    localparam int pixelBits = $clog2(pixelCount);

    // bin index taken from the timestamp msbs
    localparam int binBits = 5;
    localparam int binCount = 2 ** binBits;

    // saturating bin counters
    localparam int countWidth = 5;
    localparam int countMax = 2 ** countWidth - 1;

    // ping-pong banks, bank bit is the address msb
    localparam int bankCount = 2;
    localparam int addrWidth = 1 + pixelBits + binBits;

    // input buffer depth, equal to the sender's initial credits
    localparam int fifoDepth = 4;
    localparam int fifoPtrBits = $clog2(fifoDepth);

    // frame tag on markers and results
    localparam int frameIdWidth = 8;

endpackage

// ==== hdl/sifhTypesPkg.sv ====
package sifhTypesPkg;

    // both views of the event body are this wide
    localparam int bodyWidth = sifhCfgPkg::pixelBits + sifhCfgPkg::tsWidth;
    localparam int markerPad = bodyWidth - sifhCfgPkg::frameIdWidth;

    typedef struct packed {
        logic [sifhCfgPkg::pixelBits-1:0] pixel;
        logic [sifhCfgPkg::tsWidth-1:0] ts;
    } photonEvent;

    typedef struct packed {
        logic [markerPad-1:0] pad;
        logic [sifhCfgPkg::frameIdWidth-1:0] frameId;
    } markerEvent;

    // isMarker in the event word selects the view
    typedef union packed {
        photonEvent photon;
        markerEvent marker;
    } eventBody;

    typedef struct packed {
        logic isMarker;
        eventBody body;
    } eventWord;

    typedef struct packed {
        logic req;
        logic [sifhCfgPkg::addrWidth-1:0] addr;
    } ramReadReq;

    typedef struct packed {
        logic req;
        logic [sifhCfgPkg::addrWidth-1:0] addr;
        logic [sifhCfgPkg::countWidth-1:0] count;
    } ramWriteReq;

    typedef struct packed {
        logic valid;
        logic [sifhCfgPkg::frameIdWidth-1:0] frameId;
        logic [sifhCfgPkg::pixelBits-1:0] pixel;
        logic [sifhCfgPkg::binBits-1:0] bin;
        logic [sifhCfgPkg::countWidth-1:0] count;
    } peakResult;

endpackage

// ==== hdl/sifhEventFifo.sv ====
module sifhEventFifo (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  sifhTypesPkg::eventWord pushWord,
    input  logic pop,
    output logic headValid,
    output sifhTypesPkg::eventWord headWord,
    output logic evCredit
);

    sifhTypesPkg::eventWord mem [sifhCfgPkg::fifoDepth];

    logic [sifhCfgPkg::fifoPtrBits-1:0] wrPtr;
    logic [sifhCfgPkg::fifoPtrBits-1:0] rdPtr;
    // one extra bit so a full buffer is distinct from empty
    logic [sifhCfgPkg::fifoPtrBits:0] used;
    logic doPop;

    assign headValid = (used != 0);
    assign headWord = mem[rdPtr];
    // pop of an empty buffer is ignored
    assign doPop = pop && headValid;
    // one credit back to the sender per entry taken
    assign evCredit = doPop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else begin
            // pointers wrap, depth is a power of two
            if (push) wrPtr <= wrPtr + 1'b1;
            if (doPop) rdPtr <= rdPtr + 1'b1;
            if (push && !doPop) used <= used + 1'b1;
            else if (!push && doPop) used <= used - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= pushWord;
    end

    // sender keeps to its credits, so a push never finds the buffer full
    aNoOverflow : assert property (
        @(posedge clk) disable iff (rst)
        push |-> (used < sifhCfgPkg::fifoDepth)
    ) else $error("event pushed into a full input buffer");

endmodule

// ==== hdl/sifhHistBuilder.sv ====
module sifhHistBuilder (
    input  logic clk,
    input  logic rst,
    input  logic headValid,
    input  sifhTypesPkg::eventWord headWord,
    output logic pop,
    output sifhTypesPkg::ramReadReq rdReq,
    input  logic rdGrant,
    input  logic [sifhCfgPkg::countWidth-1:0] rdData,
    output sifhTypesPkg::ramWriteReq wrReq,
    input  logic wrGrant,
    input  logic scanBusy,
    output logic scanStart,
    output logic scanBank,
    output logic [sifhCfgPkg::frameIdWidth-1:0] scanFrameId
);

    // boot states wait out the finder's initial clear of both banks
    typedef enum logic [2:0] {
        sBoot,
        sBootWait,
        sIdle,
        sRead,
        sData,
        sWrite
    } bldState;

    bldState state;
    logic bank;
    logic [sifhCfgPkg::addrWidth-1:0] binAddr;
    logic [sifhCfgPkg::countWidth-1:0] newCount;
    sifhTypesPkg::photonEvent ph;
    logic headPhoton;
    logic headMarker;

    assign ph = headWord.body.photon;
    assign headPhoton = headValid && !headWord.isMarker;
    assign headMarker = headValid && headWord.isMarker;

    // marker only hands over once the finder is free
    assign scanStart = (state == sIdle) && headMarker && !scanBusy;
    assign scanBank = bank;
    assign scanFrameId = headWord.body.marker.frameId;
    // photon popped when its RMW starts
    assign pop = scanStart || ((state == sIdle) && headPhoton);

    always_comb begin
        rdReq.req = (state == sRead);
        rdReq.addr = binAddr;
        wrReq.req = (state == sWrite);
        wrReq.addr = binAddr;
        wrReq.count = newCount;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sBoot;
            bank <= 1'b0;
        end else begin
            case (state)
                sBoot: if (scanBusy) state <= sBootWait;
                sBootWait: if (!scanBusy) state <= sIdle;
                sIdle: begin
                    // new frame goes to the other bank
                    if (scanStart) bank <= ~bank;
                    else if (headPhoton) state <= sRead;
                end
                sRead: if (rdGrant) state <= sData;
                sData: state <= sWrite;
                sWrite: if (wrGrant) state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // address from bank, pixel and timestamp msbs
        if (state == sIdle && headPhoton) begin
            binAddr <= {bank, ph.pixel, ph.ts[sifhCfgPkg::tsWidth-1 -: sifhCfgPkg::binBits]};
        end
        // read data valid here
        // count holds at countMax
        if (state == sData) begin
            if (rdData == sifhCfgPkg::countWidth'(sifhCfgPkg::countMax)) newCount <= rdData;
            else newCount <= rdData + 1'b1;
        end
    end

    // an idle finder goes busy on the cycle after a start
    aStartWhenFree : assert property (
        @(posedge clk) disable iff (rst)
        scanStart |=> scanBusy
    ) else $error("scanStart not taken by an idle peak finder");

endmodule

// ==== hdl/sifhPeakFinder.sv ====
module sifhPeakFinder (
    input  logic clk,
    input  logic rst,
    input  logic scanStart,
    input  logic scanBank,
    input  logic [sifhCfgPkg::frameIdWidth-1:0] scanFrameId,
    output logic scanBusy,
    output sifhTypesPkg::ramReadReq rdReq,
    input  logic rdGrant,
    input  logic [sifhCfgPkg::countWidth-1:0] rdData,
    output sifhTypesPkg::ramWriteReq wrReq,
    input  logic wrGrant,
    output sifhTypesPkg::peakResult peak
);

    typedef enum logic [1:0] {
        sIdle,
        sRead,
        sData,
        sWrite
    } finState;

    finState state;
    // initial clear of both banks is pending after reset
    logic initPending;
    // clear scan, no results
    logic silent;
    logic [sifhCfgPkg::addrWidth-1:0] addr;
    logic [sifhCfgPkg::frameIdWidth-1:0] frameId;
    logic [sifhCfgPkg::binBits-1:0] maxBin;
    logic [sifhCfgPkg::countWidth-1:0] maxCount;
    logic resValid;
    logic [sifhCfgPkg::pixelBits-1:0] resPixel;
    logic [sifhCfgPkg::binBits-1:0] resBin;
    logic [sifhCfgPkg::countWidth-1:0] resCount;
    logic [sifhCfgPkg::frameIdWidth-1:0] resFrame;
    logic binLast;
    logic addrLast;
    logic writeDone;

    assign binLast = &addr[sifhCfgPkg::binBits-1:0];
    // clear scan spans both banks, a normal scan one
    assign addrLast = silent ? (&addr) : (&addr[sifhCfgPkg::addrWidth-2:0]);
    assign writeDone = (state == sWrite) && wrGrant;
    assign scanBusy = (state != sIdle);

    always_comb begin
        rdReq.req = (state == sRead);
        rdReq.addr = addr;
        // clear behind the read
        wrReq.req = (state == sWrite);
        wrReq.addr = addr;
        wrReq.count = '0;
        peak.valid = resValid;
        peak.frameId = resFrame;
        peak.pixel = resPixel;
        peak.bin = resBin;
        peak.count = resCount;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            initPending <= 1'b1;
            silent <= 1'b0;
            resValid <= 1'b0;
        end else begin
            // one result per pixel, after its last bin is cleared
            resValid <= writeDone && binLast && !silent;
            case (state)
                sIdle: begin
                    if (initPending) begin
                        initPending <= 1'b0;
                        silent <= 1'b1;
                        state <= sRead;
                    end else if (scanStart) begin
                        silent <= 1'b0;
                        state <= sRead;
                    end
                end
                sRead: if (rdGrant) state <= sData;
                sData: state <= sWrite;
                sWrite: if (wrGrant) state <= addrLast ? sIdle : sRead;
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sIdle) begin
            if (initPending) addr <= '0;
            else if (scanStart) addr <= {scanBank, {(sifhCfgPkg::addrWidth-1){1'b0}}};
            frameId <= scanFrameId;
        end else if (writeDone) begin
            addr <= addr + 1'b1;
        end
        // bin 0 restarts the max, strict compare keeps the lowest bin on ties
        if (state == sData && (addr[sifhCfgPkg::binBits-1:0] == 0 || rdData > maxCount)) begin
            maxBin <= addr[sifhCfgPkg::binBits-1:0];
            maxCount <= rdData;
        end
        if (writeDone && binLast) begin
            resFrame <= frameId;
            resPixel <= addr[sifhCfgPkg::binBits +: sifhCfgPkg::pixelBits];
            resBin <= maxBin;
            resCount <= maxCount;
        end
    end

endmodule

// ==== hdl/sifhRamArbiter.sv ====
module sifhRamArbiter (
    input  logic clk,
    input  logic rst,
    input  sifhTypesPkg::ramReadReq bldRd,
    input  sifhTypesPkg::ramReadReq finRd,
    input  sifhTypesPkg::ramWriteReq bldWr,
    input  sifhTypesPkg::ramWriteReq finWr,
    output logic bldRdGrant,
    output logic finRdGrant,
    output logic bldWrGrant,
    output logic finWrGrant,
    output sifhTypesPkg::ramReadReq ramRd,
    output sifhTypesPkg::ramWriteReq ramWr
);

    // set when the finder won the port last
    logic rdLastFin;
    logic wrLastFin;
    logic [1:0] rdPick;
    logic [1:0] wrPick;

    // grant bit 0 is the builder and bit 1 the finder
    // on contention the last loser wins
    function automatic logic [1:0] rrPick(input logic reqBld, input logic reqFin,
                                          input logic lastFin);
        logic [1:0] g;
        g = 2'b00;
        if (reqBld && reqFin) g = lastFin ? 2'b01 : 2'b10;
        else if (reqBld) g = 2'b01;
        else if (reqFin) g = 2'b10;
        return g;
    endfunction

    always_comb begin
        rdPick = rrPick(bldRd.req, finRd.req, rdLastFin);
        wrPick = rrPick(bldWr.req, finWr.req, wrLastFin);
        bldRdGrant = rdPick[0];
        finRdGrant = rdPick[1];
        bldWrGrant = wrPick[0];
        finWrGrant = wrPick[1];
        // winner drives the port
        ramRd = rdPick[1] ? finRd : bldRd;
        ramRd.req = |rdPick;
        ramWr = wrPick[1] ? finWr : bldWr;
        ramWr.req = |wrPick;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdLastFin <= 1'b0;
            wrLastFin <= 1'b0;
        end else begin
            if (|rdPick) rdLastFin <= rdPick[1];
            if (|wrPick) wrLastFin <= wrPick[1];
        end
    end

    // denied peer keeps its request and takes the port next cycle
    aRdAlternate : assert property (
        @(posedge clk) disable iff (rst)
        (bldRd.req && finRd.req) |=> (bldRdGrant != $past(bldRdGrant))
            && (finRdGrant != $past(finRdGrant))
    ) else $error("read port not passed to the waiting peer");

    aWrAlternate : assert property (
        @(posedge clk) disable iff (rst)
        (bldWr.req && finWr.req) |=> (bldWrGrant != $past(bldWrGrant))
            && (finWrGrant != $past(finWrGrant))
    ) else $error("write port not passed to the waiting peer");

endmodule

// ==== hdl/sifhBinRam.sv ====
module sifhBinRam (
    input  logic clk,
    input  sifhTypesPkg::ramReadReq ramRd,
    input  sifhTypesPkg::ramWriteReq ramWr,
    output logic [sifhCfgPkg::countWidth-1:0] rdData
);

    localparam int ramDepth = sifhCfgPkg::bankCount * sifhCfgPkg::pixelCount
                              * sifhCfgPkg::binCount;

    // bank, pixel, bin order in the address
    logic [sifhCfgPkg::countWidth-1:0] mem [ramDepth];

    always_ff @(posedge clk) begin
        if (ramWr.req) mem[ramWr.addr] <= ramWr.count;
    end

    // registered read, old value on a same-address write
    always_ff @(posedge clk) begin
        if (ramRd.req) rdData <= mem[ramRd.addr];
    end

endmodule

// ==== hdl/sifhTop.sv ====
module sifhTop (
    input  logic clk,
    input  logic rst,
    input  logic evValid,
    input  sifhTypesPkg::eventWord evWord,
    output logic evCredit,
    output sifhTypesPkg::peakResult peak
);

    logic headValid;
    sifhTypesPkg::eventWord headWord;
    logic pop;

    // builder to finder hand-off
    logic scanStart;
    logic scanBank;
    logic [sifhCfgPkg::frameIdWidth-1:0] scanFrameId;
    logic scanBusy;

    // peer requests and grants
    sifhTypesPkg::ramReadReq bldRd;
    sifhTypesPkg::ramReadReq finRd;
    sifhTypesPkg::ramWriteReq bldWr;
    sifhTypesPkg::ramWriteReq finWr;
    logic bldRdGrant;
    logic finRdGrant;
    logic bldWrGrant;
    logic finWrGrant;

    // RAM side
    sifhTypesPkg::ramReadReq ramRd;
    sifhTypesPkg::ramWriteReq ramWr;
    logic [sifhCfgPkg::countWidth-1:0] rdData;

    sifhEventFifo uFifo (
        .clk(clk), .rst(rst),
        .push(evValid), .pushWord(evWord),
        .pop(pop), .headValid(headValid), .headWord(headWord),
        .evCredit(evCredit)
    );

    sifhHistBuilder uBuilder (
        .clk(clk), .rst(rst),
        .headValid(headValid), .headWord(headWord), .pop(pop),
        .rdReq(bldRd), .rdGrant(bldRdGrant), .rdData(rdData),
        .wrReq(bldWr), .wrGrant(bldWrGrant),
        .scanBusy(scanBusy), .scanStart(scanStart),
        .scanBank(scanBank), .scanFrameId(scanFrameId)
    );

    sifhPeakFinder uFinder (
        .clk(clk), .rst(rst),
        .scanStart(scanStart), .scanBank(scanBank), .scanFrameId(scanFrameId),
        .scanBusy(scanBusy),
        .rdReq(finRd), .rdGrant(finRdGrant), .rdData(rdData),
        .wrReq(finWr), .wrGrant(finWrGrant),
        .peak(peak)
    );

    sifhRamArbiter uArbiter (
        .clk(clk), .rst(rst),
        .bldRd(bldRd), .finRd(finRd), .bldWr(bldWr), .finWr(finWr),
        .bldRdGrant(bldRdGrant), .finRdGrant(finRdGrant),
        .bldWrGrant(bldWrGrant), .finWrGrant(finWrGrant),
        .ramRd(ramRd), .ramWr(ramWr)
    );

    // read data fans out to both peers
    sifhBinRam uRam (
        .clk(clk),
        .ramRd(ramRd), .ramWr(ramWr),
        .rdData(rdData)
    );

endmodule

// ==== dv/sifhChecker.sv ====
module sifhChecker #(
    parameter int tagBits = 128
) (
    input  logic clk,
    input  logic rst,
    input  logic evValid,
    input  sifhTypesPkg::eventWord evWord,
    input  logic evCredit,
    input  sifhTypesPkg::peakResult peak,
    input  logic [tagBits-1:0] testName,
    input  logic endOfTest,
    output int resultCount,
    output int errorCount
);
    timeunit 1ns;
    timeprecision 100ps;

    // histogram of the frame now being sent
    int hist [sifhCfgPkg::pixelCount][sifhCfgPkg::binCount];
    // expected results in arrival order, with the test name of each
    sifhTypesPkg::peakResult expQ[$];
    logic [tagBits-1:0] nameQ[$];
    int credits;
    int outstanding;
    int sentCount;
    int returnedCount;
    int valueErrors = 0;
    int protocolErrors = 0;
    logic anySent;

    assign errorCount = valueErrors + protocolErrors;

    // highest bin of one pixel, the first of equal counts wins
    function automatic sifhTypesPkg::peakResult modelPeak(input int pix, input int fid);
        sifhTypesPkg::peakResult r;
        int best;
        best = 0;
        for (int b = 1; b < sifhCfgPkg::binCount; b++) begin
            if (hist[pix][b] > hist[pix][best]) best = b;
        end
        r.valid = 1'b1;
        r.frameId = sifhCfgPkg::frameIdWidth'(fid);
        r.pixel = sifhCfgPkg::pixelBits'(pix);
        r.bin = sifhCfgPkg::binBits'(best);
        r.count = sifhCfgPkg::countWidth'(hist[pix][best]);
        return r;
    endfunction

    task automatic clearHist();
        for (int p = 0; p < sifhCfgPkg::pixelCount; p++) begin
            for (int b = 0; b < sifhCfgPkg::binCount; b++) hist[p][b] = 0;
        end
    endtask

    // marker ends the frame, four results due in pixel order
    task automatic closeFrame(input int fid, input logic [tagBits-1:0] name);
        for (int p = 0; p < sifhCfgPkg::pixelCount; p++) begin
            expQ.push_back(modelPeak(p, fid));
            nameQ.push_back(name);
        end
        clearHist();
    endtask

    task automatic countPhoton(input sifhTypesPkg::photonEvent ph);
        int bin;
        // top timestamp bits pick the bin
        bin = int'(ph.ts) >> (sifhCfgPkg::tsWidth - sifhCfgPkg::binBits);
        if (hist[ph.pixel][bin] < sifhCfgPkg::countMax) hist[ph.pixel][bin]++;
    endtask

    task automatic checkField(input logic [tagBits-1:0] name, input int fid, input int pix,
                              input string field, input int expVal, input int actVal);
        if (expVal != actVal) begin
            valueErrors++;
            $display("[ERROR] %s frame %0d pixel %0d %s: expected %0d actual %0d",
                     name, fid, pix, field, expVal, actVal);
        end
    endtask

    always @(posedge clk) begin
        sifhTypesPkg::peakResult expRes;
        logic [tagBits-1:0] expName;
        if (rst) begin
            expQ.delete();
            nameQ.delete();
            clearHist();
            credits = sifhCfgPkg::fifoDepth;
            outstanding = 0;
            sentCount = 0;
            returnedCount = 0;
            resultCount = 0;
            anySent = 1'b0;
        end else begin
            // nothing comes out before the first event
            if (!anySent && (evCredit || peak.valid)) begin
                protocolErrors++;
                $display("DUT output active before any event was sent at %0t", $time);
            end
            if (evValid) begin
                if (credits == 0) begin
                    protocolErrors++;
                    $display("event sent while the sender held no credit at %0t", $time);
                end
                if (evWord.isMarker) closeFrame(int'(evWord.body.marker.frameId), testName);
                else countPhoton(evWord.body.photon);
            end
            if (evCredit && outstanding == 0) begin
                protocolErrors++;
                $display("credit returned with no event outstanding at %0t", $time);
            end
            // a pulse seen now is spendable next cycle
            credits = credits - int'(evValid) + int'(evCredit);
            outstanding = outstanding + int'(evValid) - int'(evCredit);
            sentCount += int'(evValid);
            returnedCount += int'(evCredit);
            anySent = anySent || evValid;
            if (peak.valid) begin
                resultCount++;
                if (expQ.size() == 0) begin
                    protocolErrors++;
                    $display("peak result for frame %0d pixel %0d arrived with no frame pending",
                             peak.frameId, peak.pixel);
                end else begin
                    expRes = expQ.pop_front();
                    expName = nameQ.pop_front();
                    checkField(expName, expRes.frameId, expRes.pixel, "frameId",
                               int'(expRes.frameId), int'(peak.frameId));
                    checkField(expName, expRes.frameId, expRes.pixel, "pixel",
                               int'(expRes.pixel), int'(peak.pixel));
                    checkField(expName, expRes.frameId, expRes.pixel, "bin",
                               int'(expRes.bin), int'(peak.bin));
                    checkField(expName, expRes.frameId, expRes.pixel, "count",
                               int'(expRes.count), int'(peak.count));
                end
            end
            if (endOfTest) begin
                if (expQ.size() != 0) begin
                    protocolErrors++;
                    $display("%0d expected peak results never arrived", expQ.size());
                end
                if (returnedCount != sentCount) begin
                    protocolErrors++;
                    $display("%0d credits returned for %0d events sent",
                             returnedCount, sentCount);
                end
                $display("checker: %0d events, %0d results, %0d value errors, %0d protocol errors",
                         sentCount, resultCount, valueErrors, protocolErrors);
            end
        end
    end

endmodule

// ==== dv/sifhTb.sv ====
module sifhTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tagBits = 128;
    localparam int resetCycles = 8;
    // quiet time after reset with outputs held low
    localparam int idleCycles = 100;
    // one scan address with a denied grant on each port
    localparam int addrCycles = 6;
    localparam int scanCycles = addrCycles * sifhCfgPkg::pixelCount * sifhCfgPkg::binCount;
    localparam int clearCycles = scanCycles * sifhCfgPkg::bankCount;

    logic clk;
    logic rst;
    logic evValid;
    sifhTypesPkg::eventWord evWord;
    logic evCredit;
    sifhTypesPkg::peakResult peak;
    logic [tagBits-1:0] testName;
    logic endOfTest;
    int resultCount;
    int errorCount;

    // whole stimulus built before reset
    sifhTypesPkg::eventWord evQ[$];
    // test name per event
    logic [tagBits-1:0] tagQ[$];
    int frameTotal;
    logic [sifhCfgPkg::frameIdWidth-1:0] nextFrameId;
    int limitCycles = 0;
    int credits;

    sifhTop i_dut (
        .clk(clk), .rst(rst),
        .evValid(evValid), .evWord(evWord),
        .evCredit(evCredit), .peak(peak)
    );

    sifhChecker #(.tagBits(tagBits)) uChecker (
        .clk(clk), .rst(rst),
        .evValid(evValid), .evWord(evWord), .evCredit(evCredit), .peak(peak),
        .testName(testName), .endOfTest(endOfTest),
        .resultCount(resultCount), .errorCount(errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random low timestamp bits under a chosen bin
    function automatic sifhTypesPkg::eventWord makePhoton(input int pix, input int bin);
        sifhTypesPkg::eventWord w;
        int lowBits;
        lowBits = sifhCfgPkg::tsWidth - sifhCfgPkg::binBits;
        w = '0;
        w.body.photon.pixel = sifhCfgPkg::pixelBits'(pix);
        w.body.photon.ts = sifhCfgPkg::tsWidth'((bin << lowBits) | ($urandom % (1 << lowBits)));
        return w;
    endfunction

    task automatic addEvent(input sifhTypesPkg::eventWord w, input logic [tagBits-1:0] name);
        evQ.push_back(w);
        tagQ.push_back(name);
    endtask

    task automatic addPhotons(input int pix, input int bin, input int n,
                              input logic [tagBits-1:0] name);
        for (int i = 0; i < n; i++) addEvent(makePhoton(pix, bin), name);
    endtask

    task automatic addMarker(input logic [tagBits-1:0] name);
        sifhTypesPkg::eventWord w;
        w = '0;
        w.isMarker = 1'b1;
        w.body.marker.frameId = nextFrameId;
        nextFrameId++;
        frameTotal++;
        addEvent(w, name);
    endtask

    task automatic addRandomFrame(input logic [tagBits-1:0] name);
        int n;
        int favBin;
        int bin;
        n = 20 + int'($urandom % 61);
        favBin = int'($urandom % sifhCfgPkg::binCount);
        for (int i = 0; i < n; i++) begin
            // about a third pile into one bin
            if ($urandom % 3 == 0) bin = favBin;
            else bin = int'($urandom % sifhCfgPkg::binCount);
            addEvent(makePhoton(int'($urandom % sifhCfgPkg::pixelCount), bin), name);
        end
        addMarker(name);
    endtask

    task automatic sendEvents();
        int idx;
        idx = 0;
        credits = sifhCfgPkg::fifoDepth;
        while (idx < evQ.size()) begin
            @(negedge clk);
            // random gaps and never without a credit
            if (credits > 0 && $urandom % 4 != 0) begin
                evValid = 1'b1;
                evWord = evQ[idx];
                testName = tagQ[idx];
                idx++;
                credits--;
            end else begin
                evValid = 1'b0;
            end
            // credit pulse of this cycle is spent from the next one
            if (evCredit) credits++;
        end
        @(negedge clk);
        evValid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h1c9d_72d1));
        rst = 1'b1;
        evValid = 1'b0;
        evWord = '0;
        testName = '0;
        endOfTest = 1'b0;
        frameTotal = 0;
        nextFrameId = 1;
        // 40 photons into one counter that saturates at 31
        addPhotons(2, 7, 40, "saturation");
        addMarker("saturation");
        // pixel 1 empty with ties on pixels 0 and 2
        addPhotons(0, 9, 3, "emptyAndTie");
        addPhotons(0, 5, 3, "emptyAndTie");
        addPhotons(0, 2, 1, "emptyAndTie");
        addPhotons(2, 31, 2, "emptyAndTie");
        addPhotons(2, 20, 2, "emptyAndTie");
        addPhotons(3, 0, 1, "emptyAndTie");
        addMarker("emptyAndTie");
        addPhotons(1, 3, 5, "backToBack");
        repeat (2) addMarker("backToBack");
        // same bin and bank again with no earlier counts left
        addPhotons(1, 3, 2, "bankReuse");
        addMarker("bankReuse");
        repeat (12) addRandomFrame("random");
        limitCycles = resetCycles + idleCycles + clearCycles + evQ.size() * 10
                      + frameTotal * (200 + scanCycles);
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
        repeat (idleCycles) @(negedge clk);
        sendEvents();
        while (resultCount < frameTotal * sifhCfgPkg::pixelCount) @(negedge clk);
        // room for any stray result
        repeat (50) @(negedge clk);
        endOfTest = 1'b1;
        @(negedge clk);
        endOfTest = 1'b0;
        if (errorCount == 0) $display("TEST RESULT: PASS");
        else $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog armed once the stimulus length is known
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d results seen",
                 limitCycles, resultCount, frameTotal * sifhCfgPkg::pixelCount);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sifhTop.f ====
hdl/sifhCfgPkg.sv
hdl/sifhTypesPkg.sv
hdl/sifhEventFifo.sv
hdl/sifhHistBuilder.sv
hdl/sifhPeakFinder.sv
hdl/sifhRamArbiter.sv
hdl/sifhBinRam.sv
hdl/sifhTop.sv
dv/sifhChecker.sv
dv/sifhTb.sv

// ==== Makefile ====
# Verilator simulation of the photon histogrammer testbench

VERILATOR ?= verilator
TOP ?= sifhTb
FILELIST ?= sifhTop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
